// File: logic/mem_pkg.sv
// memory subsystem package
// widths, DRAM window, response codes and the bus structs shared by
// the AXI-lite bridge, the core memory front end and the RAM

package mem_pkg;

    localparam int unsigned ADDR_WIDTH = 64;
    localparam int unsigned DATA_WIDTH = 64;
    localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;
    localparam int unsigned MEM_WORDS  = 1024;
    localparam int unsigned IDX_WIDTH  = $clog2(MEM_WORDS);

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [BE_WIDTH-1:0]   be_t;
    typedef logic [IDX_WIDTH-1:0]  word_idx_t;
    typedef logic [1:0]            resp_t;

    // byte address of RAM word 0 and size of the window in bytes
    localparam addr_t DRAM_BASE  = 64'h8000_0000;
    localparam addr_t DRAM_BYTES = addr_t'(MEM_WORDS * BE_WIDTH);

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    typedef struct packed {
        logic  aw_valid;
        addr_t aw_addr;
        logic  w_valid;
        data_t w_data;
        be_t   w_strb;
        logic  b_ready;
        logic  ar_valid;
        addr_t ar_addr;
        logic  r_ready;
    } axi_lite_req_t;

    typedef struct packed {
        logic  aw_ready;
        logic  w_ready;
        logic  b_valid;
        resp_t b_resp;
        logic  ar_ready;
        logic  r_valid;
        data_t r_data;
        resp_t r_resp;
    } axi_lite_resp_t;

    typedef struct packed {
        logic      req;
        word_idx_t addr;
        logic      we;
        data_t     wdata;
        be_t       be;
    } per_req_t;

    typedef struct packed {
        logic  gnt;
        logic  rvalid;
        data_t rdata;
    } per_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        REQ,
        WAIT_RVALID,
        B_RESP,
        R_RESP
    } bridge_state_e;

endpackage

// File: logic/sram.sv
// single-port RAM
// MEM_WORDS words of 64 bits, byte-enabled writes and a read
// registered one cycle after the enable

`timescale 1ns/100ps

module sram import mem_pkg::*; (
    input  logic      clk_i,
    input  logic      en_i,
    input  logic      we_i,
    input  word_idx_t addr_i,
    input  data_t     wdata_i,
    input  be_t       be_i,
    output data_t     rdata_o
);

    data_t mem [MEM_WORDS];

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                for (int b = 0; b < int'(BE_WIDTH); b++) begin
                    if (be_i[b]) begin
                        mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                    end
                end
            end
            // read-first, a write returns the old word
            rdata_o <= mem[addr_i];
        end
    end

endmodule

// File: logic/core_mem.sv
// core memory front end
// fixed-priority arbiter between the instruction fetch port and the
// data port onto one RAM, instruction first, with rvalid and read
// data returned to the granted port one cycle after the grant

`timescale 1ns/100ps

module core_mem import mem_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,

    input  logic      instr_req_i,
    input  word_idx_t instr_addr_i,
    output logic      instr_gnt_o,
    output logic      instr_rvalid_o,
    output data_t     instr_rdata_o,

    input  per_req_t  data_req_i,
    output per_rsp_t  data_rsp_o
);

    logic      instr_gnt;
    logic      data_gnt;

    logic      ram_en;
    logic      ram_we;
    word_idx_t ram_addr;
    data_t     ram_rdata;

    // one-hot tag of the port granted last cycle, bit 1 instr, bit 0 data
    logic [1:0] gnt_tag_q;

    assign instr_gnt = instr_req_i;
    assign data_gnt  = data_req_i.req && !instr_req_i;

    assign instr_gnt_o    = instr_gnt;
    assign data_rsp_o.gnt = data_gnt;

    // only a granted data request may write
    assign ram_en   = instr_gnt || data_gnt;
    assign ram_we   = data_gnt && data_req_i.we;
    assign ram_addr = instr_gnt ? instr_addr_i : data_req_i.addr;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            gnt_tag_q <= 2'b00;
        end else begin
            gnt_tag_q <= {instr_gnt, data_gnt};
        end
    end

    assign instr_rvalid_o    = gnt_tag_q[1];
    assign data_rsp_o.rvalid = gnt_tag_q[0];

    // steer read data to the port that owns this cycle
    assign instr_rdata_o    = gnt_tag_q[1] ? ram_rdata : '0;
    assign data_rsp_o.rdata = gnt_tag_q[0] ? ram_rdata : '0;

    sram ram_i (
        .clk_i   ( clk_i            ),
        .en_i    ( ram_en           ),
        .we_i    ( ram_we           ),
        .addr_i  ( ram_addr         ),
        .wdata_i ( data_req_i.wdata ),
        .be_i    ( data_req_i.be    ),
        .rdata_o ( ram_rdata        )
    );

endmodule

// File: logic/axi_lite_to_per.sv
// AXI-lite to peripheral bridge
// accepts one single-beat AXI-lite write or read at a time, checks the
// address against the DRAM window and turns it into a held
// request/grant/rvalid transaction, or answers DECERR straight away

`timescale 1ns/100ps

module axi_lite_to_per import mem_pkg::*; (
    input  logic           clk_i,
    input  logic           reset_i,
    input  axi_lite_req_t  axi_req_i,
    output axi_lite_resp_t axi_rsp_o,
    output per_req_t       per_req_o,
    input  per_rsp_t       per_rsp_i
);

    bridge_state_e state_q;
    bridge_state_e state_d;

    // captured transaction
    word_idx_t addr_q;
    logic      we_q;
    data_t     wdata_q;
    be_t       be_q;
    resp_t     resp_q;
    data_t     rdata_q;

    logic aw_hs;
    logic ar_hs;
    logic aw_hit;
    logic ar_hit;

    function automatic logic addr_hit(input addr_t addr);
        return (addr >= DRAM_BASE) && (addr < DRAM_BASE + DRAM_BYTES);
    endfunction

    // byte address to RAM word index
    function automatic word_idx_t addr_to_idx(input addr_t addr);
        addr_t offset;
        offset = addr - DRAM_BASE;
        return offset[3 +: IDX_WIDTH];
    endfunction

    // writes win over reads, address and data are taken together
    assign axi_rsp_o.aw_ready = (state_q == IDLE) && axi_req_i.aw_valid && axi_req_i.w_valid;
    assign axi_rsp_o.w_ready  = axi_rsp_o.aw_ready;
    assign axi_rsp_o.ar_ready = (state_q == IDLE) && !axi_req_i.aw_valid
                                && !axi_req_i.w_valid;

    assign aw_hs  = axi_rsp_o.aw_ready;
    assign ar_hs  = axi_rsp_o.ar_ready && axi_req_i.ar_valid;
    assign aw_hit = addr_hit(axi_req_i.aw_addr);
    assign ar_hit = addr_hit(axi_req_i.ar_addr);

    assign axi_rsp_o.b_valid = (state_q == B_RESP);
    assign axi_rsp_o.b_resp  = resp_q;
    assign axi_rsp_o.r_valid = (state_q == R_RESP);
    assign axi_rsp_o.r_data  = rdata_q;
    assign axi_rsp_o.r_resp  = resp_q;

    // request stays up until the memory grants it
    assign per_req_o.req   = (state_q == REQ);
    assign per_req_o.addr  = addr_q;
    assign per_req_o.we    = we_q;
    assign per_req_o.wdata = wdata_q;
    assign per_req_o.be    = be_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (aw_hs) begin
                    state_d = aw_hit ? REQ : B_RESP;
                end else if (ar_hs) begin
                    state_d = ar_hit ? REQ : R_RESP;
                end
            end
            REQ: begin
                if (per_rsp_i.gnt) begin
                    state_d = WAIT_RVALID;
                end
            end
            WAIT_RVALID: begin
                if (per_rsp_i.rvalid) begin
                    state_d = we_q ? B_RESP : R_RESP;
                end
            end
            B_RESP: begin
                if (axi_req_i.b_ready) begin
                    state_d = IDLE;
                end
            end
            R_RESP: begin
                if (axi_req_i.r_ready) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (aw_hs) begin
            addr_q  <= addr_to_idx(axi_req_i.aw_addr);
            we_q    <= 1'b1;
            wdata_q <= axi_req_i.w_data;
            be_q    <= axi_req_i.w_strb;
            resp_q  <= aw_hit ? RESP_OKAY : RESP_DECERR;
        end else if (ar_hs) begin
            addr_q  <= addr_to_idx(axi_req_i.ar_addr);
            we_q    <= 1'b0;
            be_q    <= '1;
            resp_q  <= ar_hit ? RESP_OKAY : RESP_DECERR;
            // decode error returns zero data
            if (!ar_hit) begin
                rdata_q <= '0;
            end
        end
        if (state_q == WAIT_RVALID && per_rsp_i.rvalid) begin
            rdata_q <= per_rsp_i.rdata;
        end
    end

endmodule

// File: logic/mem_subsys.sv
// memory subsystem top
// connects the AXI-lite bypass port through the bridge to the data side
// of the core memory, and the instruction fetch port straight to it

`timescale 1ns/100ps

module mem_subsys import mem_pkg::*; (
    input  logic           clk_i,
    input  logic           reset_i,

    // instruction fetch, word addressed
    input  logic           instr_req_i,
    input  word_idx_t      instr_addr_i,
    output logic           instr_gnt_o,
    output logic           instr_rvalid_o,
    output data_t          instr_rdata_o,

    // data bypass
    input  axi_lite_req_t  bypass_req_i,
    output axi_lite_resp_t bypass_rsp_o
);

    per_req_t data_req;
    per_rsp_t data_rsp;

    axi_lite_to_per axi_lite_to_per_i (
        .clk_i     ( clk_i        ),
        .reset_i   ( reset_i      ),
        .axi_req_i ( bypass_req_i ),
        .axi_rsp_o ( bypass_rsp_o ),
        .per_req_o ( data_req     ),
        .per_rsp_i ( data_rsp     )
    );

    core_mem core_mem_i (
        .clk_i          ( clk_i          ),
        .reset_i        ( reset_i        ),
        .instr_req_i    ( instr_req_i    ),
        .instr_addr_i   ( instr_addr_i   ),
        .instr_gnt_o    ( instr_gnt_o    ),
        .instr_rvalid_o ( instr_rvalid_o ),
        .instr_rdata_o  ( instr_rdata_o  ),
        .data_req_i     ( data_req       ),
        .data_rsp_o     ( data_rsp       )
    );

endmodule

// File: tb/core_tb_assert.sv
// memory subsystem protocol assertions
// instruction rvalid timing, held AXI-lite responses and the
// write-over-read rule on the bypass ready outputs

`timescale 1ns/100ps

module core_tb_assert import mem_pkg::*; (
    input logic           clk_i,
    input logic           reset_i,
    input logic           instr_gnt_o,
    input logic           instr_rvalid_o,
    input axi_lite_req_t  bypass_req_i,
    input axi_lite_resp_t bypass_rsp_o
);

    // rvalid comes exactly one cycle after the grant
    instr_rvalid_after_gnt_a: assert property (@(posedge clk_i) disable iff (reset_i)
        instr_gnt_o |=> instr_rvalid_o)
        else $error("instr_rvalid_o missing one cycle after instr_gnt_o");

    instr_rvalid_needs_gnt_a: assert property (@(posedge clk_i) disable iff (reset_i)
        instr_rvalid_o |-> $past(instr_gnt_o))
        else $error("instr_rvalid_o without a grant in the cycle before");

    // a response waiting for its ready keeps its fields
    b_held_a: assert property (@(posedge clk_i) disable iff (reset_i)
        bypass_rsp_o.b_valid && !bypass_req_i.b_ready
        |=> bypass_rsp_o.b_valid && $stable(bypass_rsp_o.b_resp))
        else $error("b channel changed before b_ready");

    r_held_a: assert property (@(posedge clk_i) disable iff (reset_i)
        bypass_rsp_o.r_valid && !bypass_req_i.r_ready
        |=> bypass_rsp_o.r_valid && $stable(bypass_rsp_o.r_data)
            && $stable(bypass_rsp_o.r_resp))
        else $error("r channel changed before r_ready");

    aw_ar_exclusive_a: assert property (@(posedge clk_i) disable iff (reset_i)
        !(bypass_rsp_o.aw_ready && bypass_rsp_o.ar_ready))
        else $error("aw_ready and ar_ready high together");

endmodule

bind mem_subsys core_tb_assert assert_i (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .instr_gnt_o    ( instr_gnt_o    ),
    .instr_rvalid_o ( instr_rvalid_o ),
    .bypass_req_i   ( bypass_req_i   ),
    .bypass_rsp_o   ( bypass_rsp_o   )
);

// File: tb/core_tb.sv
// memory subsystem testbench
// drives the AXI-lite bypass port and the instruction fetch port with
// LFSR stimulus and checks every answer against a word model

`timescale 1ns/100ps

module core_tb import mem_pkg::*;;

    localparam int TIMEOUT = 200;

    logic           clk;
    logic           reset;
    logic           instr_req;
    word_idx_t      instr_addr;
    logic           instr_gnt;
    logic           instr_rvalid;
    data_t          instr_rdata;
    axi_lite_req_t  bypass_req;
    axi_lite_resp_t bypass_rsp;

    logic [15:0] lfsr;
    data_t       model [MEM_WORDS];
    string       test_name;

    mem_subsys dut_i (
        .clk_i          ( clk          ),
        .reset_i        ( reset        ),
        .instr_req_i    ( instr_req    ),
        .instr_addr_i   ( instr_addr   ),
        .instr_gnt_o    ( instr_gnt    ),
        .instr_rvalid_o ( instr_rvalid ),
        .instr_rdata_o  ( instr_rdata  ),
        .bypass_req_i   ( bypass_req   ),
        .bypass_rsp_o   ( bypass_rsp   )
    );

    always #4 clk = ~clk;

    // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic data_t lfsr_bits(input int n);
        data_t val;
        logic  fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            val  = {val[62:0], fb};
        end
        return val;
    endfunction

    // bytes with their strobe set take the new data
    function automatic data_t merge_bytes(input data_t old, input data_t data, input be_t strb);
        data_t res;
        res = old;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic addr_t word_addr(input word_idx_t idx);
        return DRAM_BASE + (addr_t'(idx) << 3);
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check(input string what, input data_t exp, input data_t act);
        if (exp !== act) begin
            abort_run($sformatf("mismatch %s: %s expected 0x%h actual 0x%h",
                                test_name, what, exp, act));
        end
    endtask

    task automatic axi_write(input addr_t addr, input data_t data, input be_t strb,
                             input int stall, output resp_t resp);
        int cnt;
        @(posedge clk);
        bypass_req.aw_valid <= 1'b1;
        bypass_req.aw_addr  <= addr;
        bypass_req.w_valid  <= 1'b1;
        bypass_req.w_data   <= data;
        bypass_req.w_strb   <= strb;
        cnt = 0;
        @(negedge clk);
        while (!bypass_rsp.aw_ready) begin
            if (cnt == TIMEOUT) abort_run("timeout waiting for aw_ready");
            cnt++;
            @(negedge clk);
        end
        check("w_ready with aw_ready", 64'd1, data_t'(bypass_rsp.w_ready));
        @(posedge clk);
        bypass_req.aw_valid <= 1'b0;
        bypass_req.w_valid  <= 1'b0;
        cnt = 0;
        @(negedge clk);
        while (!bypass_rsp.b_valid) begin
            if (cnt == TIMEOUT) abort_run("timeout waiting for b_valid");
            cnt++;
            @(negedge clk);
        end
        resp = bypass_rsp.b_resp;
        // response must hold while b_ready stays low
        repeat (stall) begin
            @(negedge clk);
            check("b_valid held", 64'd1, data_t'(bypass_rsp.b_valid));
            check("b_resp held", data_t'(resp), data_t'(bypass_rsp.b_resp));
        end
        @(posedge clk);
        bypass_req.b_ready <= 1'b1;
        @(posedge clk);
        bypass_req.b_ready <= 1'b0;
        @(negedge clk);
        check("b_valid after accept", 64'd0, data_t'(bypass_rsp.b_valid));
    endtask

    task automatic axi_read(input addr_t addr, input int stall,
                            output resp_t resp, output data_t data);
        int cnt;
        @(posedge clk);
        bypass_req.ar_valid <= 1'b1;
        bypass_req.ar_addr  <= addr;
        cnt = 0;
        @(negedge clk);
        while (!bypass_rsp.ar_ready) begin
            if (cnt == TIMEOUT) abort_run("timeout waiting for ar_ready");
            cnt++;
            @(negedge clk);
        end
        @(posedge clk);
        bypass_req.ar_valid <= 1'b0;
        cnt = 0;
        @(negedge clk);
        while (!bypass_rsp.r_valid) begin
            if (cnt == TIMEOUT) abort_run("timeout waiting for r_valid");
            cnt++;
            @(negedge clk);
        end
        resp = bypass_rsp.r_resp;
        data = bypass_rsp.r_data;
        repeat (stall) begin
            @(negedge clk);
            check("r_valid held", 64'd1, data_t'(bypass_rsp.r_valid));
            check("r_resp held", data_t'(resp), data_t'(bypass_rsp.r_resp));
            check("r_data held", data, bypass_rsp.r_data);
        end
        @(posedge clk);
        bypass_req.r_ready <= 1'b1;
        @(posedge clk);
        bypass_req.r_ready <= 1'b0;
        @(negedge clk);
        check("r_valid after accept", 64'd0, data_t'(bypass_rsp.r_valid));
    endtask

    task automatic write_word(input word_idx_t idx, input data_t data, input be_t strb,
                              input int stall);
        resp_t resp;
        axi_write(word_addr(idx), data, strb, stall, resp);
        check("write resp", data_t'(RESP_OKAY), data_t'(resp));
        model[idx] = merge_bytes(model[idx], data, strb);
    endtask

    task automatic read_word(input word_idx_t idx, input int stall);
        resp_t resp;
        data_t data;
        axi_read(word_addr(idx), stall, resp, data);
        check("read resp", data_t'(RESP_OKAY), data_t'(resp));
        check($sformatf("read data word %0d", idx), model[idx], data);
    endtask

    // fetch one word and expect rvalid one cycle after the grant
    task automatic fetch_word(input word_idx_t idx);
        int cnt;
        @(posedge clk);
        instr_req  <= 1'b1;
        instr_addr <= idx;
        cnt = 0;
        @(negedge clk);
        while (!instr_gnt) begin
            if (cnt == TIMEOUT) abort_run("timeout waiting for instr_gnt_o");
            cnt++;
            @(negedge clk);
        end
        @(posedge clk);
        instr_req <= 1'b0;
        @(negedge clk);
        check("instr rvalid after gnt", 64'd1, data_t'(instr_rvalid));
        check($sformatf("fetch data word %0d", idx), model[idx], instr_rdata);
    endtask

    initial begin
        resp_t resp;
        data_t data;
        addr_t bad_addr;
        word_idx_t idx;
        lfsr = 16'd33372;
        clk  = 1'b0;
        reset      <= 1'b1;
        instr_req  <= 1'b0;
        instr_addr <= '0;
        bypass_req <= '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        test_name = "reset";
        @(negedge clk);
        check("b_valid", 64'd0, data_t'(bypass_rsp.b_valid));
        check("r_valid", 64'd0, data_t'(bypass_rsp.r_valid));
        check("instr_gnt", 64'd0, data_t'(instr_gnt));
        check("instr_rvalid", 64'd0, data_t'(instr_rvalid));
        check("ar_ready", 64'd1, data_t'(bypass_rsp.ar_ready));

        // fill every word so the model knows the whole RAM
        test_name = "fill";
        for (int i = 0; i < int'(MEM_WORDS); i++) begin
            write_word(word_idx_t'(i), lfsr_bits(64), 8'hff, 0);
        end
        test_name = "random strobes";
        for (int k = 0; k < 200; k++) begin
            write_word(word_idx_t'(lfsr_bits(10)), lfsr_bits(64), be_t'(lfsr_bits(8)), 0);
            read_word(word_idx_t'(lfsr_bits(10)), 0);
        end

        test_name = "decode error";
        for (int k = 0; k < 16; k++) begin
            if (k % 4 < 2) begin
                bad_addr = DRAM_BASE - 64'd8 - (addr_t'(lfsr_bits(12)) << 3);
            end else begin
                bad_addr = DRAM_BASE + (addr_t'(MEM_WORDS) << 3) + (addr_t'(lfsr_bits(12)) << 3);
            end
            if (k % 2 == 0) begin
                axi_write(bad_addr, lfsr_bits(64), 8'hff, 0, resp);
                check("write resp", data_t'(RESP_DECERR), data_t'(resp));
            end else begin
                axi_read(bad_addr, 0, resp, data);
                check("read resp", data_t'(RESP_DECERR), data_t'(resp));
                check("read data", 64'd0, data);
            end
        end
        for (int i = 0; i < int'(MEM_WORDS); i++) begin
            read_word(word_idx_t'(i), 0);
        end

        test_name = "fetch after write";
        for (int k = 0; k < 20; k++) begin
            idx = word_idx_t'(lfsr_bits(10));
            write_word(idx, lfsr_bits(64), be_t'(lfsr_bits(8)), 0);
            fetch_word(idx);
        end

        // data traffic stays in the lower half and fetches in the upper half
        test_name = "mixed traffic";
        fork
            begin : bypass_traffic
                word_idx_t bidx;
                for (int k = 0; k < 80; k++) begin
                    bidx = word_idx_t'(lfsr_bits(9));
                    if (lfsr_bits(1) == 64'd1) begin
                        write_word(bidx, lfsr_bits(64), be_t'(lfsr_bits(8)), 0);
                    end else begin
                        read_word(bidx, 0);
                    end
                end
            end
            begin : fetch_traffic
                for (int k = 0; k < 80; k++) begin
                    repeat (int'(lfsr_bits(3))) @(posedge clk);
                    fetch_word(word_idx_t'(lfsr_bits(9)) | 10'h200);
                end
            end
        join

        test_name = "back-pressure";
        for (int k = 0; k < 30; k++) begin
            idx = word_idx_t'(lfsr_bits(10));
            write_word(idx, lfsr_bits(64), be_t'(lfsr_bits(8)), int'(lfsr_bits(4)));
            read_word(idx, int'(lfsr_bits(4)));
        end
        read_word(word_idx_t'(lfsr_bits(10)), 0);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: compile.f
logic/mem_pkg.sv
logic/sram.sv
logic/core_mem.sv
logic/axi_lite_to_per.sv
logic/mem_subsys.sv
tb/core_tb_assert.sv
tb/core_tb.sv

// File: run.sh
#!/bin/sh
# build the memory subsystem testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module core_tb -f compile.f -o core_tb_sim \
    && ./obj_dir/core_tb_sim > sim.log 2>&1 \
    || echo "simulation build or run ended with an error" >> sim.log
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0
